/* src/usbTx_macros.svh */
`ifndef USB_TX_MACROS_SVH
`define USB_TX_MACROS_SVH

// sent LSB first this gives KJKJKJKK on the line.
`define USB_SYNC_BYTE 8'h80

`define USB_CRC5_POLY 16'h0005
`define USB_CRC16_POLY 16'h8005
`define USB_CRC_PRESET 16'hffff

// remainders left by a good packet when the receiver runs its CRC over the CRC field too.
`define USB_CRC5_RESIDUE 5'b01100
`define USB_CRC16_RESIDUE 16'h800d

`define USB_STUFF_RUN 6
`define USB_EOP_SE0_BITS 2

`define USB_LINE_J 2'b10
`define USB_LINE_K 2'b01
`define USB_LINE_SE0 2'b00

`endif

/* src/usbTxPkg.sv */
package usbTxPkg;

    // one byte of a packet, PID included.
    typedef logic [7:0] usbByte_t;

    typedef logic [15:0] usbCrc_t;       // CRC5 lives in the low five bits.

    typedef logic [1:0] usbLineState_t;  // {dp, dn}.

    // the kind follows PID bits 1:0 directly.
    typedef enum logic [1:0] {
        kindSpecial   = 2'b00,
        kindToken     = 2'b01,
        kindHandshake = 2'b10,
        kindData      = 2'b11
    } usbPidKind_t;

    typedef enum logic [2:0] {
        stIdle,
        stSync,
        stPid,
        stData,
        stCrc,
        stEop
    } framerState_t;

endpackage

/* src/usbCrc.sv */
`timescale 1ns/1ns
`include "usbTx_macros.svh"

module usbCrc (
    input logic clk12_i,
    input logic arstN_i,
    input logic clear_i,
    input logic use16_i,
    input logic bit_i,
    input logic bitValid_i,
    output usbTxPkg::usbCrc_t crc_o
);
    import usbTxPkg::*;

    usbCrc_t crcReg;
    usbCrc_t crcNext;
    usbCrc_t poly;
    usbCrc_t rev16;
    logic [4:0] rev5;
    logic feedback;

    // the MSB of the active width is compared with the incoming bit.
    always_comb begin
        poly = use16_i ? `USB_CRC16_POLY : `USB_CRC5_POLY;
        feedback = bit_i ^ (use16_i ? crcReg[15] : crcReg[4]);
        crcNext = {crcReg[14:0], 1'b0} ^ (feedback ? poly : '0);
    end

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            crcReg <= `USB_CRC_PRESET;
        end else if (clear_i) begin
            crcReg <= `USB_CRC_PRESET;
        end else if (bitValid_i) begin
            crcReg <= crcNext;
        end
    end

    // the remainder goes out MSB first, so reverse it for an LSB first shifter.
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            rev16[i] = ~crcReg[15 - i];
        end
        for (int i = 0; i < 5; i++) begin
            rev5[i] = ~crcReg[4 - i];
        end
    end

    assign crc_o = use16_i ? rev16 : {11'b0, rev5};

endmodule

/* src/usbBitStuffer.sv */
`timescale 1ns/1ns
`include "usbTx_macros.svh"

module usbBitStuffer (
    input logic clk12_i,
    input logic arstN_i,
    input logic clear_i,
    input logic bit_i,
    input logic bitValid_i,
    output logic stuffedBit_o,
    output logic stuffedBitValid_o,
    output logic stuffStall_o
);
    logic [2:0] onesCnt;

    // a full run means the next slot on the line is the stuffed zero.
    assign stuffStall_o = (onesCnt == 3'(`USB_STUFF_RUN));

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            onesCnt <= 3'd0;
            stuffedBitValid_o <= 1'b0;
        end else if (clear_i) begin
            onesCnt <= 3'd0;
            stuffedBitValid_o <= 1'b0;
        end else if (stuffStall_o) begin
            onesCnt <= 3'd0;  // the inserted zero breaks the run.
            stuffedBitValid_o <= 1'b1;
        end else if (bitValid_i) begin
            onesCnt <= bit_i ? onesCnt + 3'd1 : 3'd0;
            stuffedBitValid_o <= 1'b1;
        end else begin
            stuffedBitValid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk12_i) begin
        stuffedBit_o <= stuffStall_o ? 1'b0 : bit_i;
    end

endmodule

/* src/usbTxFramer.sv */
`timescale 1ns/1ns
`include "usbTx_macros.svh"

module usbTxFramer (
    input logic clk12_i,
    input logic arstN_i,

    input logic txReqSendPacket_i,
    output logic txAcceptNewData_o,
    input logic txIsLastByte_i,
    input logic txDataValid_i,
    input usbTxPkg::usbByte_t txData_i,

    output logic crcClear_o,
    output logic crcUse16_o,
    output logic crcBit_o,
    output logic crcBitValid_o,
    input usbTxPkg::usbCrc_t crc_i,

    input logic stuffStall_i,
    output logic stuffClear_o,
    output logic rawBit_o,
    output logic rawBitValid_o,
    output logic eopReq_o
);
    import usbTxPkg::*;

    framerState_t state;
    usbPidKind_t pidKind;
    usbByte_t curByte;
    logic [3:0] bitCnt;
    logic [3:0] crcLastBit;
    logic curIsLast;
    logic advance;
    logic needsCrc;
    logic byteStage;
    logic takeByte;

    assign advance = !stuffStall_i;  // a stuffed zero holds the current bit.
    assign needsCrc = (pidKind == kindToken) || (pidKind == kindData);
    assign byteStage = (state == stPid) || (state == stData);
    assign crcLastBit = crcUse16_o ? 4'd15 : 4'd4;

    // the next byte is fetched while the last bit of the current one is on its way.
    assign txAcceptNewData_o = advance && (bitCnt == 4'd7) &&
        ((state == stSync) || (byteStage && needsCrc && !curIsLast));
    assign takeByte = txAcceptNewData_o && txDataValid_i;

    assign crcUse16_o = (pidKind == kindData);
    assign crcClear_o = (state == stPid) && (bitCnt == 4'd0);
    assign crcBit_o = curByte[bitCnt[2:0]];
    assign crcBitValid_o = (state == stData) && advance;

    assign stuffClear_o = (state == stIdle);
    assign rawBitValid_o = (state == stSync) || byteStage || (state == stCrc);
    assign rawBit_o = (state == stCrc) ? crc_i[bitCnt] : curByte[bitCnt[2:0]];

    // issued once the stuffer has flushed its last bit.
    assign eopReq_o = (state == stEop) && (bitCnt == 4'd0) && advance;

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= stIdle;
            bitCnt <= 4'd0;
            pidKind <= kindSpecial;
            curIsLast <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (txReqSendPacket_i) begin
                        state <= stSync;
                        bitCnt <= 4'd0;
                    end
                end
                stSync: begin
                    if (advance) begin
                        if (bitCnt == 4'd7) begin
                            bitCnt <= 4'd0;
                            if (takeByte) begin
                                state <= stPid;
                                pidKind <= usbPidKind_t'(txData_i[1:0]);
                                curIsLast <= txIsLastByte_i;
                            end else begin
                                state <= stEop;  // no PID arrived, close the line.
                            end
                        end else begin
                            bitCnt <= bitCnt + 4'd1;
                        end
                    end
                end
                stPid, stData: begin
                    if (advance) begin
                        if (bitCnt == 4'd7) begin
                            bitCnt <= 4'd0;
                            if (takeByte) begin
                                state <= stData;
                                curIsLast <= txIsLastByte_i;
                            end else if (needsCrc) begin
                                state <= stCrc;
                            end else begin
                                state <= stEop;
                            end
                        end else begin
                            bitCnt <= bitCnt + 4'd1;
                        end
                    end
                end
                stCrc: begin
                    if (advance) begin
                        if (bitCnt == crcLastBit) begin
                            state <= stEop;
                            bitCnt <= 4'd0;
                        end else begin
                            bitCnt <= bitCnt + 4'd1;
                        end
                    end
                end
                stEop: begin
                    // stay busy until the line driver has finished SE0 and J.
                    if (bitCnt == 4'd0) begin
                        if (advance) begin
                            bitCnt <= 4'd1;
                        end
                    end else if (bitCnt == 4'(`USB_EOP_SE0_BITS + 1)) begin
                        state <= stIdle;
                        bitCnt <= 4'd0;
                    end else begin
                        bitCnt <= bitCnt + 4'd1;
                    end
                end
                default: begin
                    state <= stIdle;
                    bitCnt <= 4'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clk12_i) begin
        if (state == stIdle) begin
            curByte <= `USB_SYNC_BYTE;
        end else if (takeByte) begin
            curByte <= txData_i;
        end
    end

endmodule

/* src/usbTxLineDriver.sv */
`timescale 1ns/1ns
`include "usbTx_macros.svh"

module usbTxLineDriver (
    input logic clk12_i,
    input logic arstN_i,
    input logic bit_i,
    input logic bitValid_i,
    input logic eopReq_i,
    output logic usbDp_o,
    output logic usbDn_o,
    output logic sending_o
);
    import usbTxPkg::*;

    usbLineState_t lineState;
    logic nextLevel;
    logic eopReqQ;
    logic [1:0] eopCnt;

    // NRZI: a one keeps the level, a zero flips it.
    assign nextLevel = bit_i ? lineState[1] : ~lineState[1];

    always_ff @(posedge clk12_i or negedge arstN_i) begin
        if (!arstN_i) begin
            lineState <= `USB_LINE_J;
            sending_o <= 1'b0;
            eopReqQ <= 1'b0;
            eopCnt <= 2'd0;
        end else begin
            eopReqQ <= eopReq_i;  // aligns with the last bit out of the stuffer.
            if (bitValid_i) begin
                lineState <= {nextLevel, ~nextLevel};
                sending_o <= 1'b1;
            end else if (eopReqQ) begin
                lineState <= `USB_LINE_SE0;
                eopCnt <= 2'd1;
            end else if (eopCnt != 2'd0) begin
                if (eopCnt == 2'(`USB_EOP_SE0_BITS)) begin
                    lineState <= `USB_LINE_J;
                end
                if (eopCnt == 2'(`USB_EOP_SE0_BITS + 1)) begin
                    eopCnt <= 2'd0;
                    sending_o <= 1'b0;  // J has been on the line for one bit time.
                end else begin
                    eopCnt <= eopCnt + 2'd1;
                end
            end
        end
    end

    assign usbDp_o = lineState[1];
    assign usbDn_o = lineState[0];

endmodule

/* src/usbTxTop.sv */
`timescale 1ns/1ns

module usbTxTop (
    input logic clk12_i,
    input logic arstN_i,

    input logic txReqSendPacket_i,
    output logic txAcceptNewData_o,
    input logic txIsLastByte_i,
    input logic txDataValid_i,
    input usbTxPkg::usbByte_t txData_i,

    output logic usbDp_o,
    output logic usbDn_o,
    output logic sending_o
);
    import usbTxPkg::*;

    logic crcClear;
    logic crcUse16;
    logic crcBit;
    logic crcBitValid;
    usbCrc_t crcValue;

    logic stuffClear;
    logic stuffStall;
    logic rawBit;
    logic rawBitValid;
    logic stuffedBit;
    logic stuffedBitValid;
    logic eopReq;

    usbTxFramer framer_i (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .txReqSendPacket_i(txReqSendPacket_i),
        .txAcceptNewData_o(txAcceptNewData_o),
        .txIsLastByte_i(txIsLastByte_i),
        .txDataValid_i(txDataValid_i),
        .txData_i(txData_i),
        .crcClear_o(crcClear),
        .crcUse16_o(crcUse16),
        .crcBit_o(crcBit),
        .crcBitValid_o(crcBitValid),
        .crc_i(crcValue),
        .stuffStall_i(stuffStall),
        .stuffClear_o(stuffClear),
        .rawBit_o(rawBit),
        .rawBitValid_o(rawBitValid),
        .eopReq_o(eopReq)
    );

    usbCrc crcEngine_i (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .clear_i(crcClear),
        .use16_i(crcUse16),
        .bit_i(crcBit),
        .bitValid_i(crcBitValid),
        .crc_o(crcValue)
    );

    usbBitStuffer stuffer_i (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .clear_i(stuffClear),
        .bit_i(rawBit),
        .bitValid_i(rawBitValid),
        .stuffedBit_o(stuffedBit),
        .stuffedBitValid_o(stuffedBitValid),
        .stuffStall_o(stuffStall)
    );

    usbTxLineDriver lineDriver_i (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .bit_i(stuffedBit),
        .bitValid_i(stuffedBitValid),
        .eopReq_i(eopReq),
        .usbDp_o(usbDp_o),
        .usbDn_o(usbDn_o),
        .sending_o(sending_o)
    );

endmodule

/* test/usbTxTbChecks.svh */
localparam int MAX_BYTES = 12;
localparam int MAX_BITS = 8 * (MAX_BYTES + 1) + 16;

logic expBits [MAX_BITS];
int expLen;
int expCrcLen;
int expStuffed;
usbCrc_t expCrc;

// expected bits before stuffing, SYNC first and every field LSB first.
function automatic void buildExpected(input usbByte_t bytes [MAX_BYTES], input int nBytes);
    usbPidKind_t kind;
    usbByte_t syncByte;
    usbCrc_t crc;
    usbCrc_t poly;
    logic fb;
    int run;
    kind = usbPidKind_t'(bytes[0][1:0]);
    syncByte = `USB_SYNC_BYTE;
    expLen = 0;
    for (int i = 0; i < 8; i++) begin
        expBits[expLen] = syncByte[i];
        expLen++;
    end
    for (int n = 0; n < nBytes; n++) begin
        for (int i = 0; i < 8; i++) begin
            expBits[expLen] = bytes[n][i];
            expLen++;
        end
    end
    expCrcLen = (kind == kindData) ? 16 : (kind == kindToken) ? 5 : 0;
    poly = (kind == kindData) ? `USB_CRC16_POLY : `USB_CRC5_POLY;
    crc = `USB_CRC_PRESET;
    expCrc = '0;
    if (expCrcLen > 0) begin
        for (int k = 16; k < expLen; k++) begin  // the CRC covers everything after the PID.
            fb = expBits[k] ^ crc[expCrcLen - 1];
            crc = {crc[14:0], 1'b0} ^ (fb ? poly : 16'h0000);
        end
        for (int j = 0; j < expCrcLen; j++) begin
            expCrc[j] = ~crc[expCrcLen - 1 - j];  // the remainder goes out inverted and high bit first.
            expBits[expLen] = expCrc[j];
            expLen++;
        end
    end
    // a zero follows every run of six ones even at the very end.
    expStuffed = 0;
    run = 0;
    for (int k = 0; k < expLen; k++) begin
        run = expBits[k] ? run + 1 : 0;
        if (run == `USB_STUFF_RUN) begin
            expStuffed++;
            run = 0;
        end
    end
endfunction

task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        reportFailure($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
endtask

task automatic checkByte(input usbByte_t got, input usbByte_t exp, input string what);
    if (got !== exp) begin
        reportFailure($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic checkCrc(input usbCrc_t got, input usbCrc_t exp, input string what);
    if (got !== exp) begin
        reportFailure($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic checkLine(input usbLineState_t got, input usbLineState_t exp, input string what);
    if (got !== exp) begin
        reportFailure($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
endtask

/* test/usbTxTb.sv */
`timescale 1ns/1ns
`include "usbTx_macros.svh"

module usbTxTb;
    import usbTxPkg::*;

    logic clk12_i;
    logic arstN_i;
    logic txReqSendPacket_i;
    logic txAcceptNewData_o;
    logic txIsLastByte_i;
    logic txDataValid_i;
    usbByte_t txData_i;
    logic usbDp_o;
    logic usbDn_o;
    logic sending_o;

    int errorCount = 0;
    int cycleCount = 0;
    int packetsSent = 0;
    int packetsChecked = 0;
    int seed;

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopping at the first failed check");
    endtask

    `include "usbTxTbChecks.svh"

    usbByte_t pktBytes [MAX_BYTES];
    int pktLen;

    // what the line monitor has collected for the current packet.
    logic gotBits [MAX_BITS];
    int gotLen = 0;
    int stuffSeen = 0;
    int onesRun = 0;
    int se0Seen = 0;
    int jSeen = 0;
    logic prevLevel = 1'b1;
    logic inPacket = 1'b0;

    // six packets with 30 bytes in all, 24 bits of SYNC and CRC each, one stuffed bit per
    // six and about 15 cycles of start, EOP and gap per packet.
    localparam int PACKET_BITS = 6 * 24 + 8 * 30;
    localparam int TIMEOUT_CYCLES = 16 + PACKET_BITS + PACKET_BITS / 6 + 6 * 15 + 200;

    usbTxTop dut_i (
        .clk12_i(clk12_i),
        .arstN_i(arstN_i),
        .txReqSendPacket_i(txReqSendPacket_i),
        .txAcceptNewData_o(txAcceptNewData_o),
        .txIsLastByte_i(txIsLastByte_i),
        .txDataValid_i(txDataValid_i),
        .txData_i(txData_i),
        .usbDp_o(usbDp_o),
        .usbDn_o(usbDn_o),
        .sending_o(sending_o)
    );

    always #50 clk12_i = ~clk12_i;

    always @(posedge clk12_i) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the packets never completed", cycleCount);
            $display("Checks failed");
            $fatal(1, "simulation hit its cycle limit");
        end
    end

    task automatic comparePacket();
        usbByte_t gotByte;
        usbByte_t expByte;
        usbCrc_t gotCrc;
        usbCrc_t residue;
        usbCrc_t expResidue;
        usbCrc_t poly;
        logic fb;
        if (gotLen != expLen || stuffSeen != expStuffed) begin
            reportFailure($sformatf("error at %0t ns: %0d bits and %0d stuffed, expected %0d and %0d",
                $time, gotLen, stuffSeen, expLen, expStuffed));
        end
        if (se0Seen != `USB_EOP_SE0_BITS || jSeen != 1) begin
            reportFailure($sformatf("error at %0t ns: EOP had %0d SE0 and %0d J, expected %0d and 1",
                $time, se0Seen, jSeen, `USB_EOP_SE0_BITS));
        end
        for (int n = 0; n <= pktLen; n++) begin
            for (int i = 0; i < 8; i++) begin
                gotByte[i] = gotBits[8 * n + i];
                expByte[i] = expBits[8 * n + i];
            end
            checkByte(gotByte, expByte, $sformatf("byte %0d of packet %0d", n, packetsChecked));
        end
        if (expCrcLen > 0) begin
            gotCrc = '0;
            for (int j = 0; j < expCrcLen; j++) begin
                gotCrc[j] = gotBits[8 * (pktLen + 1) + j];
            end
            checkCrc(gotCrc, expCrc, $sformatf("CRC of packet %0d", packetsChecked));

            // a receiver running its CRC over the data and the CRC field ends on a fixed residue.
            poly = (expCrcLen == 16) ? `USB_CRC16_POLY : `USB_CRC5_POLY;
            expResidue = (expCrcLen == 16) ? `USB_CRC16_RESIDUE : 16'(`USB_CRC5_RESIDUE);
            residue = `USB_CRC_PRESET;
            for (int k = 16; k < gotLen; k++) begin
                fb = gotBits[k] ^ residue[expCrcLen - 1];
                residue = {residue[14:0], 1'b0} ^ (fb ? poly : 16'h0000);
            end
            if (expCrcLen == 5) begin
                residue = residue & 16'h001f;
            end
            checkCrc(residue, expResidue, $sformatf("CRC residue of packet %0d", packetsChecked));
        end
    endtask

    // samples the line in the middle of each bit time.
    always @(negedge clk12_i) begin : lineMonitor
        usbLineState_t line;
        logic bitNow;
        line = {usbDp_o, usbDn_o};
        if (arstN_i && sending_o) begin
            inPacket = 1'b1;
            if (line == `USB_LINE_SE0) begin
                se0Seen++;
            end else if (se0Seen > 0) begin
                checkLine(line, `USB_LINE_J, "line after SE0");
                jSeen++;
            end else if (gotLen >= MAX_BITS) begin
                reportFailure("the packet on the line is longer than any packet that was sent");
            end else begin
                checkBit(usbDn_o, ~usbDp_o, "usbDn_o against usbDp_o");
                bitNow = (usbDp_o == prevLevel);  // no transition means a one.
                prevLevel = usbDp_o;
                if (onesRun == `USB_STUFF_RUN) begin
                    checkBit(bitNow, 1'b0, "stuffed bit");
                    stuffSeen++;
                    onesRun = 0;
                end else begin
                    gotBits[gotLen] = bitNow;
                    gotLen++;
                    onesRun = bitNow ? onesRun + 1 : 0;
                end
            end
        end else if (arstN_i) begin
            if (inPacket) begin
                comparePacket();
                packetsChecked++;
                inPacket = 1'b0;
                gotLen = 0;
                stuffSeen = 0;
                onesRun = 0;
                se0Seen = 0;
                jSeen = 0;
                prevLevel = 1'b1;
            end
            checkLine(line, `USB_LINE_J, "idle line");
            checkBit(txAcceptNewData_o, 1'b0, "txAcceptNewData_o while idle");
        end
    end

    task automatic loadPacket(input usbByte_t pid, input int payloadLen, input logic allOnes);
        pktLen = payloadLen + 1;
        pktBytes[0] = pid;
        for (int i = 1; i < pktLen; i++) begin
            pktBytes[i] = allOnes ? 8'hff : 8'($random(seed));
        end
    endtask

    // returns once the last byte has been taken while the packet is still on the line.
    task automatic sendPacket();
        int idx;
        buildExpected(pktBytes, pktLen);
        idx = 0;
        @(posedge clk12_i);
        txReqSendPacket_i <= 1'b1;
        txData_i <= pktBytes[0];
        txDataValid_i <= 1'b1;
        txIsLastByte_i <= (pktLen == 1);
        @(posedge clk12_i);
        txReqSendPacket_i <= 1'b0;
        while (idx < pktLen) begin
            @(negedge clk12_i);
            if (txAcceptNewData_o) begin
                @(posedge clk12_i);
                idx++;
                if (idx < pktLen) begin
                    txData_i <= pktBytes[idx];
                    txIsLastByte_i <= (idx == pktLen - 1);
                end else begin
                    txDataValid_i <= 1'b0;
                    txIsLastByte_i <= 1'b0;
                end
            end
        end
    endtask

    task automatic sendAndCheck();
        sendPacket();
        packetsSent++;
        wait (packetsChecked == packetsSent);
        repeat (4) @(posedge clk12_i);
    endtask

    initial begin
        seed = 32'hf9b07cef;
        clk12_i = 1'b0;
        arstN_i = 1'b0;
        txReqSendPacket_i = 1'b0;
        txIsLastByte_i = 1'b0;
        txDataValid_i = 1'b0;
        txData_i = '0;
        repeat (16) @(posedge clk12_i);
        arstN_i <= 1'b1;
        repeat (4) @(posedge clk12_i);

        loadPacket(8'hd2, 0, 1'b0);  // ACK.
        sendAndCheck();
        loadPacket(8'he1, 2, 1'b0);  // OUT token.
        sendAndCheck();
        loadPacket(8'hc3, 8, 1'b0);
        sendAndCheck();
        loadPacket(8'h4b, 8, 1'b1);  // all ones, so stuffing runs into the CRC.
        sendAndCheck();

        // a request while the packet is on the line has to be dropped.
        loadPacket(8'hc3, 4, 1'b0);
        sendPacket();
        packetsSent++;
        @(negedge clk12_i);
        checkBit(sending_o, 1'b1, "sending_o at the early request");
        @(posedge clk12_i);
        txReqSendPacket_i <= 1'b1;
        @(posedge clk12_i);
        txReqSendPacket_i <= 1'b0;
        wait (packetsChecked == packetsSent);
        repeat (8) @(negedge clk12_i);
        checkBit(sending_o, 1'b0, "sending_o after the dropped request");
        loadPacket(8'h69, 2, 1'b0);  // IN token sent for the request issued again.
        sendAndCheck();

        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+src
+incdir+test
src/usbTxPkg.sv
src/usbCrc.sv
src/usbBitStuffer.sv
src/usbTxFramer.sv
src/usbTxLineDriver.sv
src/usbTxTop.sv
test/usbTxTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module usbTxTb -f compile.f -o usbTxSim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/usbTxSim > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log

grep -q "Checks failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
